/* include/rom_macros.svh */
`ifndef ROM_MACROS_SVH
`define ROM_MACROS_SVH

// ##########################################################################
// Download side
// ##########################################################################

// Byte address of the download stream
`define ROM_DL_AW 14

// ##########################################################################
// Program banks
// ##########################################################################

`define ROM_BANK_AW 10 // Words per bank as a power of two
`define ROM_PROG_BANKS 3 // Banks in the program region
`define ROM_SEL_W 2 // Bank index, value 3 is the hole

// ##########################################################################
// Audio bank
// ##########################################################################

`define ROM_AUD_AW 11 // Byte address inside the audio bank

// First download byte of the audio region
`define ROM_AUD_BASE 14'h2000

`endif

/* verilog/rom_pkg.sv */
`include "rom_macros.svh"

package rom_pkg;

	// Payload types
	typedef logic [15:0] rom_word_t; // Program word, big-endian pair
	typedef logic [7:0] rom_byte_t; // Download and audio byte

	// Address types
	typedef logic [`ROM_DL_AW-1:0] dl_addr_t; // Host byte address

	// Game side program address
	// Upper bits pick the bank, lower bits the word inside it
	typedef logic [`ROM_SEL_W+`ROM_BANK_AW-1:0] prog_addr_t;

	typedef logic [`ROM_AUD_AW-1:0] aud_addr_t; // Audio byte address

	// Where a download byte lands
	typedef enum logic [1:0] {
		REGION_PROG = 2'd0, // Packed into a program word
		REGION_AUDIO = 2'd1, // Written straight to the audio bank
		REGION_NONE = 2'd2 // Hole or past the end, dropped
	} region_e;

endpackage

/* verilog/rom_wr_if.sv */
`timescale 1ns/10ps
`include "rom_macros.svh"

// Bank write requests, one strobe per completed write
interface rom_wr_if import rom_pkg::*; ();

	logic [`ROM_PROG_BANKS-1:0] prog_we; // One-hot program bank strobe
	logic aud_we; // Audio bank strobe
	logic [`ROM_AUD_AW-1:0] waddr; // Shared by all banks
	rom_word_t wdata_word; // Program payload
	rom_byte_t wdata_byte; // Audio payload

	modport loader (
		output prog_we,
		output aud_we,
		output waddr,
		output wdata_word,
		output wdata_byte
	);

	// Program banks use the low ROM_BANK_AW bits of waddr
	modport bank (
		input prog_we,
		input aud_we,
		input waddr,
		input wdata_word,
		input wdata_byte
	);

endinterface

/* verilog/rom_bank.sv */
`timescale 1ns/10ps

// Simple dual-port store
// Port A writes from the loader, port B reads for the game
module rom_bank #(
	parameter type data_t = logic [7:0],
	parameter int AW = 8
) (
	input logic clk_sys,
	input logic we,
	input logic [AW-1:0] waddr,
	input data_t wdata,
	input logic [AW-1:0] raddr,
	output data_t rdata
);

	localparam int DEPTH = 1 << AW;

	data_t mem [DEPTH]; // Contents hold across reset

	// Port A
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Port B
	// Same-address read during a write returns the old word
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr]; // One cycle latency
	end

endmodule

/* verilog/rom_loader.sv */
`timescale 1ns/10ps
`include "rom_macros.svh"

module rom_loader import rom_pkg::*; (
	input logic clk_sys,
	input logic rst,
	input logic dl_active,
	input logic dl_wr,
	input dl_addr_t dl_addr,
	input rom_byte_t dl_data,
	rom_wr_if.loader wr
);

	// Region limits in download bytes
	localparam int PROG_END = `ROM_PROG_BANKS << (`ROM_BANK_AW + 1); // Start of the hole
	localparam int AUD_END = `ROM_AUD_BASE + (1 << `ROM_AUD_AW);

	logic accept; // Byte taken this edge
	region_e region;
	logic [`ROM_SEL_W-1:0] bank_idx;
	logic [`ROM_PROG_BANKS-1:0] bank_onehot;
	aud_addr_t aud_off; // Offset inside the audio region
	rom_byte_t acc_hi; // Even byte waiting for its partner
	logic prog_wr; // Odd program byte completes a word
	logic aud_wr;

	assign accept = dl_wr & dl_active;
	assign bank_idx = dl_addr[`ROM_BANK_AW+1 +: `ROM_SEL_W]; // 2 KB per bank
	assign aud_off = aud_addr_t'(dl_addr - dl_addr_t'(`ROM_AUD_BASE));

	// ##########################################################################
	// Region decode
	// ##########################################################################

	always_comb begin
		if (dl_addr < dl_addr_t'(PROG_END)) begin
			region = REGION_PROG;
		end else if (dl_addr >= dl_addr_t'(`ROM_AUD_BASE) &&
			dl_addr < dl_addr_t'(AUD_END)) begin
			region = REGION_AUDIO;
		end else begin
			region = REGION_NONE; // Filler hole and anything above audio
		end
	end

	always_comb begin
		for (int i = 0; i < `ROM_PROG_BANKS; i++) begin
			bank_onehot[i] = (int'(bank_idx) == i);
		end
	end

	assign prog_wr = accept && region == REGION_PROG && dl_addr[0];
	assign aud_wr = accept && region == REGION_AUDIO;

	// ##########################################################################
	// Accumulator and write strobes
	// ##########################################################################

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr.prog_we <= '0;
			wr.aud_we <= 1'b0;
			acc_hi <= '0;
		end else begin
			wr.prog_we <= '0; // Strobes last one cycle
			wr.aud_we <= aud_wr;
			if (accept && region == REGION_PROG) begin
				if (!dl_addr[0]) begin
					acc_hi <= dl_data; // High half of the word
				end else begin
					wr.prog_we <= bank_onehot;
				end
			end
		end
	end

	// Write payload follows the strobe
	always_ff @(posedge clk_sys) begin
		if (prog_wr) begin
			wr.waddr <= {{(`ROM_AUD_AW - `ROM_BANK_AW){1'b0}}, dl_addr[`ROM_BANK_AW:1]};
			wr.wdata_word <= {acc_hi, dl_data}; // Big-endian pair
		end
		if (aud_wr) begin
			wr.waddr <= aud_off;
			wr.wdata_byte <= dl_data;
		end
	end

	// No two banks written in the same cycle
	assert property (@(posedge clk_sys) disable iff (rst)
		$onehot0({wr.prog_we, wr.aud_we}))
		else $error("rom_loader: more than one bank write enable high");

endmodule

/* verilog/rom_read_mux.sv */
`timescale 1ns/10ps
`include "rom_macros.svh"

module rom_read_mux import rom_pkg::*; (
	input logic clk_sys,
	input logic rst,
	input logic prog_rd,
	input logic [`ROM_SEL_W-1:0] bank_sel,
	input rom_word_t bank_data [`ROM_PROG_BANKS],
	output rom_word_t prog_data,
	output logic prog_valid
);

	localparam logic [`ROM_SEL_W-1:0] SEL_HOLE = '1; // Index past the last bank

	logic [`ROM_SEL_W-1:0] sel_q; // Lines up with the bank read
	logic valid_q;

	// ##########################################################################
	// Select and valid pipeline
	// ##########################################################################

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sel_q <= SEL_HOLE; // Output reads zero until the first read
			valid_q <= 1'b0;
		end else begin
			sel_q <= bank_sel;
			valid_q <= prog_rd;
		end
	end

	// ##########################################################################
	// Data select
	// ##########################################################################

	always_comb begin
		prog_data = '0; // Hole reads zero
		for (int i = 0; i < `ROM_PROG_BANKS; i++) begin
			if (int'(sel_q) == i) begin
				prog_data = bank_data[i];
			end
		end
	end

	assign prog_valid = valid_q;

	// Valid arrives with the bank data of the request
	assert property (@(posedge clk_sys) disable iff (rst)
		##1 prog_valid == $past(prog_rd))
		else $error("rom_read_mux: prog_valid not one cycle after prog_rd");

endmodule

/* verilog/rom_store_top.sv */
`timescale 1ns/10ps
`include "rom_macros.svh"

module rom_store_top import rom_pkg::*; (
	input logic clk_sys,
	input logic rst,

	// Download stream from the host
	input logic dl_active,
	input logic dl_wr,
	input dl_addr_t dl_addr,
	input rom_byte_t dl_data,

	// Program read port
	input logic prog_rd,
	input prog_addr_t prog_addr,
	output rom_word_t prog_data,
	output logic prog_valid,

	// Audio read port
	input aud_addr_t aud_addr,
	output rom_byte_t aud_data
);

	logic [`ROM_SEL_W-1:0] bank_sel; // Upper program address bits
	logic [`ROM_BANK_AW-1:0] prog_word; // Word inside the bank
	rom_word_t bank_rdata [`ROM_PROG_BANKS];

	assign bank_sel = prog_addr[`ROM_BANK_AW +: `ROM_SEL_W];
	assign prog_word = prog_addr[`ROM_BANK_AW-1:0];

	rom_wr_if wr_bus ();

	// ##########################################################################
	// Download side
	// ##########################################################################

	rom_loader rom_loader_inst (
		.clk_sys(clk_sys),
		.rst(rst),
		.dl_active(dl_active),
		.dl_wr(dl_wr),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.wr(wr_bus.loader)
	);

	// ##########################################################################
	// Storage
	// ##########################################################################

	// Program banks, read in parallel, picked after the read
	for (genvar g = 0; g < `ROM_PROG_BANKS; g++) begin : g_prog_bank
		rom_bank #(
			.data_t(rom_word_t),
			.AW(`ROM_BANK_AW)
		) rom_bank_inst (
			.clk_sys(clk_sys),
			.we(wr_bus.prog_we[g]),
			.waddr(wr_bus.waddr[`ROM_BANK_AW-1:0]),
			.wdata(wr_bus.wdata_word),
			.raddr(prog_word),
			.rdata(bank_rdata[g])
		);
	end

	// Audio bank, byte wide
	rom_bank #(
		.data_t(rom_byte_t),
		.AW(`ROM_AUD_AW)
	) aud_bank_inst (
		.clk_sys(clk_sys),
		.we(wr_bus.aud_we),
		.waddr(wr_bus.waddr),
		.wdata(wr_bus.wdata_byte),
		.raddr(aud_addr),
		.rdata(aud_data) // Byte of last cycle's address
	);

	// ##########################################################################
	// Program read path
	// ##########################################################################

	rom_read_mux rom_read_mux_inst (
		.clk_sys(clk_sys),
		.rst(rst),
		.prog_rd(prog_rd),
		.bank_sel(bank_sel),
		.bank_data(bank_rdata),
		.prog_data(prog_data),
		.prog_valid(prog_valid)
	);

endmodule

/* test/tb_rom_store.sv */
`timescale 1ns/10ps
`include "rom_macros.svh"

module tb_rom_store import rom_pkg::*; ();

	localparam int IMAGE_BYTES = 10240; // Program, hole and audio regions
	localparam int PROG_WORDS = 1 << (`ROM_SEL_W + `ROM_BANK_AW); // Includes the hole
	localparam int AUD_BYTES = 1 << `ROM_AUD_AW;
	localparam int HOLE_BASE = 32'h1800; // First filler byte
	localparam int AUD_BASE = 32'h2000;
	localparam int TIMEOUT_CYCLES = 40000;
	localparam logic [31:0] LCG_SEED = 32'h9fbb6a13;

	logic clk_sys = 1'b0;
	logic rst;
	logic dl_active;
	logic dl_wr;
	dl_addr_t dl_addr;
	rom_byte_t dl_data;
	logic prog_rd;
	prog_addr_t prog_addr;
	rom_word_t prog_data;
	logic prog_valid;
	aud_addr_t aud_addr;
	rom_byte_t aud_data;

	rom_byte_t image [IMAGE_BYTES]; // Host side copy of the download
	prog_addr_t rd_addr_q [$]; // Reads in flight
	int rd_cyc_q [$]; // Cycle each read was issued in
	int cycle_cnt = 0;

	always #20 clk_sys = ~clk_sys; // 40 ns period

	rom_store_top rom_store_top_inst (
		.clk_sys(clk_sys),
		.rst(rst),
		.dl_active(dl_active),
		.dl_wr(dl_wr),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.prog_rd(prog_rd),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.prog_valid(prog_valid),
		.aud_addr(aud_addr),
		.aud_data(aud_data)
	);

	// ##########################################################################
	// Helpers
	// ##########################################################################

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, expected);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants
	endfunction

	// Word w sits at bytes 2w and 2w+1, even byte high
	function automatic rom_word_t expected_word(input prog_addr_t a);
		int byte_addr;
		byte_addr = int'(a) * 2;
		if (byte_addr >= HOLE_BASE) begin
			return '0; // Filler hole
		end
		return {image[byte_addr], image[byte_addr + 1]};
	endfunction

	function automatic rom_byte_t expected_byte(input aud_addr_t a);
		return image[AUD_BASE + int'(a)];
	endfunction

	// ##########################################################################
	// Cycle counter and timeout
	// ##########################################################################

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// ##########################################################################
	// Program read compare, sampled mid cycle
	// ##########################################################################

	always @(negedge clk_sys) begin : compare_proc
		prog_addr_t addr;
		int issued;
		if (!rst) begin
			if (prog_valid) begin
				if (rd_addr_q.size() == 0) begin
					$display("prog_valid went high at %0t ns with no read outstanding", $time);
					abort_run();
				end
				addr = rd_addr_q.pop_front();
				issued = rd_cyc_q.pop_front();
				check_value("prog_valid latency", 32'(cycle_cnt), 32'(issued + 1));
				check_value($sformatf("prog_data at %h", addr), 32'(prog_data),
					32'(expected_word(addr)));
			end else if (rd_cyc_q.size() != 0 && rd_cyc_q[0] < cycle_cnt) begin
				$display("prog_valid missing at %0t ns for address %h", $time, rd_addr_q[0]);
				abort_run();
			end
		end
	end

	// ##########################################################################
	// Stimulus
	// ##########################################################################

	task automatic download_image(input logic active, input logic invert);
		for (int i = 0; i < IMAGE_BYTES; i++) begin
			@(posedge clk_sys);
			#2;
			dl_active = active;
			dl_wr = 1'b1;
			dl_addr = dl_addr_t'(i);
			dl_data = invert ? ~image[i] : image[i]; // Junk for the ignored pass
		end
		@(posedge clk_sys);
		#2;
		dl_wr = 1'b0;
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys); // Last strobe lands in the bank
	endtask

	// Back to back reads over the banks and the hole
	task automatic read_program();
		for (int a = 0; a < PROG_WORDS; a++) begin
			@(posedge clk_sys);
			#2;
			prog_rd = 1'b1;
			prog_addr = prog_addr_t'(a);
			rd_addr_q.push_back(prog_addr_t'(a));
			rd_cyc_q.push_back(cycle_cnt);
		end
		@(posedge clk_sys);
		#2;
		prog_rd = 1'b0;
		while (rd_addr_q.size() != 0) begin
			@(posedge clk_sys);
		end
	endtask

	// Address in one cycle, byte checked in the next
	task automatic read_audio();
		for (int a = 0; a <= AUD_BYTES; a++) begin
			@(posedge clk_sys);
			#2;
			if (a > 0) begin
				check_value($sformatf("aud_data at %h", a - 1), 32'(aud_data),
					32'(expected_byte(aud_addr_t'(a - 1))));
			end
			if (a < AUD_BYTES) begin
				aud_addr = aud_addr_t'(a);
			end
		end
	endtask

	initial begin : main_proc
		logic [31:0] state;
		rst = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		prog_rd = 1'b0;
		prog_addr = '0;
		aud_addr = '0;

		state = LCG_SEED;
		for (int i = 0; i < IMAGE_BYTES; i++) begin
			state = lcg_next(state);
			image[i] = state[31:24]; // Upper bits are the most random
		end

		repeat (10) @(posedge clk_sys);
		#2;
		rst = 1'b0;

		// 1. Idle after reset, compare process flags any stray prog_valid
		repeat (8) @(posedge clk_sys);

		// 2 to 4. Full download then read everything back
		download_image(1'b1, 1'b0);
		read_program();
		read_audio();

		// 5. Inactive pass with inverted data changes nothing
		download_image(1'b0, 1'b1);
		read_program();
		read_audio();

		$display("TB PASSED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
verilog/rom_pkg.sv
verilog/rom_wr_if.sv
verilog/rom_bank.sv
verilog/rom_loader.sv
verilog/rom_read_mux.sv
verilog/rom_store_top.sv
test/tb_rom_store.sv

/* Makefile */
# Verilator build and run for the ROM download store

VERILATOR ?= verilator
FILELIST ?= vlog.f
TOP ?= tb_rom_store
RTL_TOP ?= rom_store_top
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SRCS := $(shell grep -v '^+' $(FILELIST)) include/rom_macros.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status of the simulator is the result
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
